//--- common/rv_pkg.sv
// Shared types for the RV32I pipeline core
// Holds the meaningful widths, the supported opcodes, the ALU operation
// encoding and the payload structs carried between pipeline stages.
// Modules import it inside their body; port lists use scoped names.

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes of the nine supported instructions
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or
  } alu_op_e;

  // Decoded controls; all zero is a bubble
  typedef struct packed {
    logic    alu_src;
    logic    mem_to_reg;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t    ctrl;
    addr_t    pc;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_read;
    logic     mem_write;
    xlen_t    alu_result;
    xlen_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  // Write-back result, also the retire view
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xlen_t    data;
  } retire_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    xlen_t data;
  } store_t;

endpackage

//--- fetch/rv_fetch.sv
// Fetch stage of the pipeline core
// Holds the PC, reads the instruction ROM and registers the fetched
// word into the fetch/decode register. A taken branch reloads the PC
// and turns the fetch/decode register into a bubble.

`timescale 1ns/1ps

module rv_fetch #(
  parameter int imem_words = 64
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          branch_taken,
  input  rv_pkg::addr_t branch_target,
  input  logic          flush,
  output rv_pkg::addr_t if_pc,
  output rv_pkg::inst_t if_inst
);
  import rv_pkg::*;

  localparam int imem_aw = $clog2(imem_words);

  inst_t              rom [imem_words];
  logic [imem_aw-1:0] rom_idx;
  addr_t              pc;
  addr_t              pc_next;
  inst_t              inst;

  // Unfilled words stay zero and decode as bubbles
  // Path is relative to the run directory
  initial
  begin
    for (int i = 0; i < imem_words; i++)
    begin
      rom[i] = '0;
    end
    $readmemh("dv/program.hex", rom);
  end

  // Word addressed, byte offset dropped
  assign rom_idx = pc[imem_aw+1:2];
  assign inst    = rom[rom_idx];
  assign pc_next = branch_taken ? branch_target : pc + 32'd4;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= '0;
    end
    else
    begin
      pc <= pc_next;
    end
  end

  ////////////////////
  // Fetch/decode register
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      if_pc   <= '0;
      if_inst <= '0;
    end
    else if (flush)
    begin
      if_pc   <= '0;
      if_inst <= '0;
    end
    else
    begin
      if_pc   <= pc;
      if_inst <= inst;
    end
  end

endmodule

//--- decode/rv_regfile.sv
// Integer register file, two read ports and one write port
// x0 is hardwired to zero. A write and a read of the same register in
// one cycle return the new value through the write-through path.

`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::retire_t  wb,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  xlen_t regs [1:31];

  function automatic xlen_t read_port(input reg_idx_t idx);
    if (idx == '0)
      return '0;
    else if (wb.valid && wb.rd == idx)
      return wb.data;
    else
      return regs[idx];
  endfunction

  // Reads follow the array and the write-back entry as well as the index
  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb.valid && wb.rd != '0)
    begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

//--- decode/rv_decode.sv
// Decode stage of the pipeline core
// Turns the fetched word into a control bundle and an immediate, reads
// the register file and registers the payload for execute. Unsupported
// encodings get an all-zero control bundle and travel as bubbles.
// flush zeroes the controls of the next decode/execute entry.

`timescale 1ns/1ps

module rv_decode (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::addr_t   if_pc,
  input  rv_pkg::inst_t   if_inst,
  input  logic            flush,
  input  rv_pkg::retire_t wb,
  output rv_pkg::id_ex_t  id_ex
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b30;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm;
  ctrl_t      ctrl;

  assign opcode     = if_inst[6:0];
  assign rd         = if_inst[11:7];
  assign funct3     = if_inst[14:12];
  assign rs1        = if_inst[19:15];
  assign rs2        = if_inst[24:20];
  assign funct7_b30 = if_inst[30];

  // Sign-extended immediates
  assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
  assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
  assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                  if_inst[11:8], 1'b0};

  rv_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .wb      (wb),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  ////////////////////
  // Control decode
  ////////////////////
  always_comb
  begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      op_rtype:
      begin
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7_b30 ? alu_sub : alu_add;
          3'b111:  ctrl.alu_op = alu_and;
          3'b110:  ctrl.alu_op = alu_or;
          default: ctrl = '0;
        endcase
      end
      op_itype:
      begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_i;
        case (funct3)
          3'b000:  ctrl.alu_op = alu_add;
          3'b110:  ctrl.alu_op = alu_or;
          default: ctrl = '0;
        endcase
      end
      op_load:
      begin
        if (funct3 == 3'b010)
        begin
          ctrl.alu_src    = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_read   = 1'b1;
          imm             = imm_i;
        end
      end
      op_store:
      begin
        if (funct3 == 3'b010)
        begin
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
          imm            = imm_s;
        end
      end
      op_branch:
      begin
        // beq compares by subtraction
        if (funct3 == 3'b000)
        begin
          ctrl.branch = 1'b1;
          ctrl.alu_op = alu_sub;
          imm         = imm_b;
        end
      end
      default: ctrl = '0;
    endcase
  end

  ////////////////////
  // Decode/execute register
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      id_ex <= '0;
    end
    else
    begin
      id_ex.ctrl     <= flush ? ctrl_t'('0) : ctrl;
      id_ex.pc       <= if_pc;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
      id_ex.rd       <= rd;
    end
  end

endmodule

//--- execute/rv_execute.sv
// Execute stage of the pipeline core
// Selects the second operand, runs the ALU and resolves beq. The branch
// decision and target leave this stage combinationally so that fetch
// and decode can redirect on the following edge.

`timescale 1ns/1ps

module rv_execute (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::id_ex_t  id_ex,
  output rv_pkg::ex_mem_t ex_mem,
  output logic            branch_taken,
  output rv_pkg::addr_t   branch_target
);
  import rv_pkg::*;

  xlen_t operand_b;
  xlen_t alu_result;
  logic  alu_zero;

  // Immediate for I-type, loads and stores
  assign operand_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rs2_data;

  ////////////////////
  // ALU
  ////////////////////
  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      alu_add: alu_result = id_ex.rs1_data + operand_b;
      alu_sub: alu_result = id_ex.rs1_data - operand_b;
      alu_and: alu_result = id_ex.rs1_data & operand_b;
      alu_or:  alu_result = id_ex.rs1_data | operand_b;
      default: alu_result = '0;
    endcase
  end

  assign alu_zero = (alu_result == '0);

  // beq taken when the operands are equal
  assign branch_taken  = id_ex.ctrl.branch & alu_zero;
  assign branch_target = id_ex.pc + id_ex.imm;

  ////////////////////
  // Execute/memory register
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ex_mem <= '0;
    end
    else
    begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.alu_result <= alu_result;
      // Store data is always rs2, never the immediate
      ex_mem.store_data <= id_ex.rs2_data;
      ex_mem.rd         <= id_ex.rd;
    end
  end

endmodule

//--- verilog/rv_mem_wb.sv
// Memory and write-back stage of the pipeline core
// Holds the word-addressed data RAM with asynchronous read and clocked
// write. Drives the store view straight from the execute/memory entry
// and registers the selected result into the write-back entry.

`timescale 1ns/1ps

module rv_mem_wb #(
  parameter int dmem_words = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::store_t  store,
  output rv_pkg::retire_t wb
);
  import rv_pkg::*;

  localparam int dmem_aw = $clog2(dmem_words);

  xlen_t              dmem [dmem_words];
  logic [dmem_aw-1:0] dmem_idx;
  xlen_t              load_data;
  xlen_t              wb_data;

  assign dmem_idx  = ex_mem.alu_result[dmem_aw+1:2];
  assign load_data = ex_mem.mem_read ? dmem[dmem_idx] : '0;
  assign wb_data   = ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;

  always_ff @(posedge clk)
  begin
    if (ex_mem.mem_write)
    begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  // Store view, same cycle as the RAM write
  assign store = '{valid: ex_mem.mem_write,
                   addr:  ex_mem.alu_result,
                   data:  ex_mem.store_data};

  ////////////////////
  // Memory/write-back register
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wb <= '0;
    end
    else
    begin
      // Writes to x0 never become valid
      wb.valid <= ex_mem.reg_write && (ex_mem.rd != '0);
      wb.rd    <= ex_mem.rd;
      wb.data  <= wb_data;
    end
  end

endmodule

//--- verilog/rv_core.sv
// Top level of the five-stage RV32I pipeline core
// Joins fetch, decode, execute and the memory/write-back stage.
// Exposes every written-back result on retire and every data memory
// write on store, both as plain one-cycle strobes.
// Set the memory depths here; they are passed down to the stages.

`timescale 1ns/1ps

module rv_core #(
  parameter int imem_words = 64,
  parameter int dmem_words = 64
) (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::retire_t retire,
  output rv_pkg::store_t  store
);
  import rv_pkg::*;

  addr_t   if_pc;
  inst_t   if_inst;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  retire_t wb;
  logic    branch_taken;
  addr_t   branch_target;

  assign retire = wb;

  rv_fetch #(.imem_words(imem_words)) u_fetch (
    .clk          (clk),
    .rst          (rst),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .flush        (branch_taken),
    .if_pc        (if_pc),
    .if_inst      (if_inst)
  );

  rv_decode u_decode (
    .clk    (clk),
    .rst    (rst),
    .if_pc  (if_pc),
    .if_inst(if_inst),
    .flush  (branch_taken),
    .wb     (wb),
    .id_ex  (id_ex)
  );

  rv_execute u_execute (
    .clk          (clk),
    .rst          (rst),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .branch_taken (branch_taken),
    .branch_target(branch_target)
  );

  rv_mem_wb #(.dmem_words(dmem_words)) u_mem_wb (
    .clk   (clk),
    .rst   (rst),
    .ex_mem(ex_mem),
    .store (store),
    .wb    (wb)
  );

endmodule

//--- dv/rv_core_assertions.sv
// Bound checks for the pipeline core
// Attached to rv_core with bind. Watches the retire and store views,
// the fetch/decode word and the decode/execute controls.

`timescale 1ns/1ps

module rv_core_assertions (
  input logic            clk,
  input logic            rst,
  input rv_pkg::retire_t retire,
  input rv_pkg::store_t  store,
  input logic            branch_taken,
  input rv_pkg::inst_t   if_inst,
  input rv_pkg::id_ex_t  id_ex
);
  import rv_pkg::*;

  int         fail_count = 0;
  logic [3:0] cycles;

  // Edges since reset release, saturating
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cycles <= '0;
    end
    else if (cycles != 4'hf)
    begin
      cycles <= cycles + 4'd1;
    end
  end

  ////////////////////
  // Reset and startup
  ////////////////////
  reset_quiet: assert property (@(posedge clk) rst |-> !retire.valid && !store.valid)
  else
  begin
    $error("retire or store active while reset is held");
    fail_count++;
  end

  no_early_retire: assert property (@(posedge clk) disable iff (rst)
    cycles < 4'd4 |-> !retire.valid)
  else
  begin
    $error("retire active before the first instruction could reach it");
    fail_count++;
  end

  no_early_store: assert property (@(posedge clk) disable iff (rst)
    cycles < 4'd3 |-> !store.valid)
  else
  begin
    $error("store active before the first instruction could reach it");
    fail_count++;
  end

  // Word 0 writes a register, so it retires four edges after its fetch
  first_retire: assert property (@(posedge clk) disable iff (rst)
    cycles == 4'd4 |-> retire.valid)
  else
  begin
    $error("first instruction did not retire four cycles after its fetch");
    fail_count++;
  end

  ////////////////////
  // x0 and flush
  ////////////////////
  x0_no_retire: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.rd != 5'd0)
  else
  begin
    $error("a write to x0 showed up on retire");
    fail_count++;
  end

  flush_bubbles: assert property (@(posedge clk) disable iff (rst)
    branch_taken |=> if_inst == '0 && id_ex.ctrl == ctrl_t'('0))
  else
  begin
    $error("taken beq did not turn the two younger stages into bubbles");
    fail_count++;
  end

endmodule

bind rv_core rv_core_assertions u_assertions (
  .clk         (clk),
  .rst         (rst),
  .retire      (retire),
  .store       (store),
  .branch_taken(branch_taken),
  .if_inst     (if_inst),
  .id_ex       (id_ex)
);

//--- dv/rv_core_tb.sv
// Testbench for the RV32I pipeline core
// Runs dv/program.hex on the core and on an instruction-level model of
// the nine instructions, then compares every retire and store strobe
// with the model's ordered lists. Bound assertions cover reset, x0 and
// the branch flush. Build with Verilator --binary --timing.

`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int imem_words = 64;
  localparam int dmem_words = 64;
  localparam int max_cycles = 100;

  logic    clk;
  logic    rst;
  retire_t retire;
  store_t  store;

  inst_t   prog [imem_words];
  retire_t exp_retire [$];
  store_t  exp_store [$];
  int      errors;
  int      timeouts;
  int      retire_seen;
  int      store_seen;
  int      wait_cycles;

  rv_core #(.imem_words(imem_words), .dmem_words(dmem_words)) dut (
    .clk   (clk),
    .rst   (rst),
    .retire(retire),
    .store (store)
  );

  always #5 clk = ~clk;

  function automatic xlen_t imm_i(input inst_t inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  function automatic xlen_t imm_s(input inst_t inst);
    return {{20{inst[31]}}, inst[31:25], inst[11:7]};
  endfunction

  function automatic xlen_t imm_b(input inst_t inst);
    return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic int word_index(input addr_t addr);
    return int'((addr >> 2) % dmem_words);
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  task automatic build_expected();
    xlen_t   regs [32];
    xlen_t   dmem [dmem_words];
    addr_t   pc;
    addr_t   next_pc;
    inst_t   inst;
    xlen_t   a;
    xlen_t   b;
    xlen_t   res;
    logic    wr;
    int      steps;
    retire_t r;
    store_t  s;
    for (int i = 0; i < 32; i++)
    begin
      regs[i] = '0;
    end
    for (int i = 0; i < dmem_words; i++)
    begin
      dmem[i] = '0;
    end
    pc = '0;
    steps = 0;
    // Runs off the end of the ROM; the tail words are bubbles
    while (int'(pc >> 2) < imem_words && steps < 4 * imem_words)
    begin
      inst = prog[int'(pc >> 2)];
      a = regs[inst[19:15]];
      b = regs[inst[24:20]];
      wr = 1'b0;
      res = '0;
      next_pc = pc + 32'd4;
      steps++;
      case (inst[6:0])
        op_rtype:
        begin
          wr = 1'b1;
          case (inst[14:12])
            3'b000:  res = inst[30] ? a - b : a + b;
            3'b111:  res = a & b;
            3'b110:  res = a | b;
            default: wr = 1'b0;
          endcase
        end
        op_itype:
        begin
          wr = 1'b1;
          case (inst[14:12])
            3'b000:  res = a + imm_i(inst);
            3'b110:  res = a | imm_i(inst);
            default: wr = 1'b0;
          endcase
        end
        op_load:
        begin
          if (inst[14:12] == 3'b010)
          begin
            wr = 1'b1;
            res = dmem[word_index(a + imm_i(inst))];
          end
        end
        op_store:
        begin
          if (inst[14:12] == 3'b010)
          begin
            dmem[word_index(a + imm_s(inst))] = b;
            s.valid = 1'b1;
            s.addr = a + imm_s(inst);
            s.data = b;
            exp_store.push_back(s);
          end
        end
        op_branch:
        begin
          if (inst[14:12] == 3'b000 && a == b)
          begin
            next_pc = pc + imm_b(inst);
          end
        end
        default: ;
      endcase
      // x0 writes are dropped and never retire
      if (wr && inst[11:7] != 5'd0)
      begin
        regs[inst[11:7]] = res;
        r.valid = 1'b1;
        r.rd = inst[11:7];
        r.data = res;
        exp_retire.push_back(r);
      end
      pc = next_pc;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst && retire.valid)
    begin
      if (retire_seen >= exp_retire.size())
      begin
        errors++;
        $display("Unexpected retire of x%0d beyond the expected list", retire.rd);
      end
      else
      begin
        assert (retire == exp_retire[retire_seen])
        else
        begin
          errors++;
          $display("ERR retire[%0d]: expected rd=%0d data=%h, actual rd=%0d data=%h",
                   retire_seen, exp_retire[retire_seen].rd, exp_retire[retire_seen].data,
                   retire.rd, retire.data);
        end
      end
      retire_seen++;
    end
    if (!rst && store.valid)
    begin
      if (store_seen >= exp_store.size())
      begin
        errors++;
        $display("Unexpected store to %h beyond the expected list", store.addr);
      end
      else
      begin
        assert (store == exp_store[store_seen])
        else
        begin
          errors++;
          $display("ERR store[%0d]: expected addr=%h data=%h, actual addr=%h data=%h",
                   store_seen, exp_store[store_seen].addr, exp_store[store_seen].data,
                   store.addr, store.data);
        end
      end
      store_seen++;
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    errors = 0;
    timeouts = 0;
    retire_seen = 0;
    store_seen = 0;
    for (int i = 0; i < imem_words; i++)
    begin
      prog[i] = '0;
    end
    $readmemh("dv/program.hex", prog);
    build_expected();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    wait_cycles = 0;
    while ((retire_seen < exp_retire.size() || store_seen < exp_store.size())
           && wait_cycles < max_cycles)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (retire_seen < exp_retire.size() || store_seen < exp_store.size())
    begin
      timeouts++;
      $display("Timed out waiting for the expected retires and stores");
    end

    // Quiet period, nothing else may retire or store
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
    end

    $display("Errors: %0d wrong values, %0d timeouts, %0d assertion failures",
             errors, timeouts, dut.u_assertions.fail_count);
    if (errors == 0 && timeouts == 0 && dut.u_assertions.fail_count == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- dv/program.hex
// One 32-bit instruction word per line, word 0 first
// Dependent instructions stay at least three slots apart
00500093  // addi x1, x0, 5
00C00113  // addi x2, x0, 12
04000193  // addi x3, x0, 64
0F606293  // ori  x5, x0, 0x0f6
00208233  // add  x4, x1, x2
40110333  // sub  x6, x2, x1
0022F3B3  // and  x7, x5, x2
0050E433  // or   x8, x1, x5
0041A423  // sw   x4, 8(x3)
00708013  // addi x0, x1, 7
10036493  // ori  x9, x6, 0x100
0081A503  // lw   x10, 8(x3)
00108663  // beq  x1, x1, +12 (taken)
06300593  // addi x11, x0, 99 (flushed)
0011A023  // sw   x1, 0(x3) (flushed)
00120463  // beq  x4, x1, +8 (not taken)
00950633  // add  x12, x10, x9
401006B3  // sub  x13, x0, x1

//--- sources.f
common/rv_pkg.sv
fetch/rv_fetch.sv
decode/rv_regfile.sv
decode/rv_decode.sv
execute/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
